// File: list.f
cdr_pkg.sv
cfg_regs.sv
adc_unfold.sv
mm_phase_detector.sv
cdr_loop_filter.sv
pi_ctl_map.sv
prbs_checker.sv
cdr_core.sv
cdr_core_props.sv
tb_cdr_core.sv

// File: Makefile
SIM      = verilator
TOP      = tb_cdr_core
FILELIST = list.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cdr_core.sv
module tb_cdr_core;
    timeunit 1ns;
    timeprecision 1ps;

    import cdr_pkg::*;

    localparam int RST_CYCLES = 5;
    localparam int WARMUP     = 40;
    localparam int RUN_LEN    = 80;
    localparam int N_RUNS     = 12;
    localparam int HS_MAX     = 16;
    localparam int PLANNED    = RST_CYCLES + WARMUP + 2 * HS_MAX + 1
                                + N_RUNS * (RUN_LEN + 2 * HS_MAX + 1);

    logic             clk_adc;
    logic             cdr_rstb;
    adc_frame_t       adc_frame_i;
    logic             cdr_cfg_req_i;
    cdr_cfg_t         cdr_cfg_i;
    logic             cdr_cfg_ack_o;
    logic             prbs_cfg_req_i;
    prbs_cfg_t        prbs_cfg_i;
    logic             prbs_cfg_ack_o;
    logic             ctl_valid_o;
    pi_vec_t          pi_ctl_o;
    logic [CNT_W-1:0] err_count_o;
    logic [CNT_W-1:0] total_count_o;

    // reference model state per pipeline stage
    bit [1:0]                  m_ack;
    cdr_cfg_t                  m_cdr;
    prbs_cfg_t                 m_prbs;
    int                        m_codes [NTI];
    int                        m_prev;
    int                        m_pd;
    int                        m_edges;
    logic signed [INTEG_W-1:0] m_integ;
    logic [PHASE_W-1:0]        m_phase;
    bit [NTI-1:0]              m_bits;
    bit [1:7]                  m_hist;
    longint                    m_err;
    longint                    m_tot;

    // g_hist[i] is the prbs7 bit sent i positions earlier
    bit [1:7] g_hist;
    bit       tx_inv;
    int       errors;
    int       checks;

    cdr_core dut (.*);

    initial begin
        clk_adc = 1'b0;
        forever #5 clk_adc = ~clk_adc;
    end

    initial begin
        #(2 * PLANNED * 10);
        $display("timeout: run still going after %0d clock cycles", 2 * PLANNED);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check(input longint got, input longint want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, advanced once per rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic model_edge();
        int x [NTI+1];
        logic signed [INTEG_W-1:0] integ_old;
        bit b;
        if (!cdr_rstb) begin
            m_ack = '0;
            m_cdr = '0;
            m_cdr.kp_shift = 2;
            m_cdr.ki_shift = 6;
            m_cdr.max_sel = '1;
            m_prbs = '0;
            m_prev = 0;
            m_pd = 0;
            m_edges = 0;
            m_integ = '0;
            m_phase = '0;
            m_bits = '0;
            m_hist = '0;
            m_err = 0;
            m_tot = 0;
            foreach (m_codes[k]) m_codes[k] = 0;
            return;
        end
        // later stages first so each sees the values from before the edge
        for (int k = 0; k < NTI; k++) begin
            b = m_bits[k];
            if (m_prbs.enable && m_prbs.chan_sel[k]) begin
                m_tot++;
                m_err += b ^ m_hist[7] ^ m_hist[6];
            end
            m_hist = {b, m_hist[1:6]};
        end
        for (int k = 0; k < NTI; k++) begin
            m_bits[k] = (m_codes[k] > int'($signed(m_prbs.thresh))) ^ m_prbs.invert;
        end
        integ_old = m_integ;
        if (m_edges < CTL_WAIT) begin
            m_integ = '0;
            m_phase = '0;
        end else begin
            m_integ = m_integ + INTEG_W'(m_pd >>> m_cdr.ki_shift);
            m_phase = m_phase + PHASE_W'(m_pd >>> m_cdr.kp_shift) + PHASE_W'(integ_old);
        end
        x[0] = m_prev;
        foreach (m_codes[k]) x[k+1] = m_codes[k];
        m_pd = 0;
        for (int k = 1; k <= NTI; k++) begin
            m_pd += ((x[k-1] >= 0) ? x[k] : -x[k]) - ((x[k] >= 0) ? x[k-1] : -x[k-1]);
        end
        m_prev = m_codes[NTI-1];
        for (int k = 0; k < NTI; k++) begin
            m_codes[k] = adc_frame_i.sign[k] ? -int'(adc_frame_i.mag[k])
                                             : int'(adc_frame_i.mag[k]);
        end
        if (m_edges < CTL_WAIT) m_edges++;
        // four-phase slaves
        if (cdr_cfg_req_i && !m_ack[0]) begin
            m_cdr = cdr_cfg_i;
            m_ack[0] = 1'b1;
        end else if (!cdr_cfg_req_i && m_ack[0]) begin
            m_ack[0] = 1'b0;
        end
        if (prbs_cfg_req_i && !m_ack[1]) begin
            m_prbs = prbs_cfg_i;
            m_ack[1] = 1'b1;
        end else if (!prbs_cfg_req_i && m_ack[1]) begin
            m_ack[1] = 1'b0;
        end
    endtask

    task automatic compare_outputs();
        int raw;
        int scale;
        raw = int'(m_phase[PHASE_W-1 -: NPI]);
        check(ctl_valid_o, m_edges >= CTL_WAIT, "ctl_valid_o");
        check(cdr_cfg_ack_o, m_ack[0], "cdr_cfg_ack_o");
        check(prbs_cfg_ack_o, m_ack[1], "prbs_cfg_ack_o");
        for (int j = 0; j < NOUT; j++) begin
            scale = (int'(m_cdr.max_sel[j]) + 1) * 16 - 1;
            check(pi_ctl_o[j], (raw % scale + int'(m_cdr.pi_offset[j])) % (1 << NPI),
                  $sformatf("pi_ctl_o[%0d]", j));
            // phase is zero in the startup wait so only the offset shows
            if (m_edges < CTL_WAIT) begin
                check(pi_ctl_o[j], m_cdr.pi_offset[j], "pi_ctl_o during startup wait");
            end
        end
        check(err_count_o, m_err, "err_count_o");
        check(total_count_o, m_tot, "total_count_o");
    endtask

    // prbs7 bits as +/- random magnitudes, sparse flips and noise frames
    task automatic drive_frame();
        adc_frame_t f;
        bit b;
        for (int k = 0; k < NTI; k++) begin
            b = g_hist[7] ^ g_hist[6];
            g_hist = {b, g_hist[1:6]};
            if ($urandom_range(63) == 0) b = ~b;
            f.mag[k] = NADC'($urandom_range(255, 1));
            f.sign[k] = ~(b ^ tx_inv);
        end
        if ($urandom_range(31) == 0) begin
            f.mag = 32'($urandom);
            f.sign = NTI'($urandom);
        end
        adc_frame_i = f;
    endtask

    task automatic wait_ack(input bit to_prbs, input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk_adc);
            #1;
            n++;
        end while ((to_prbs ? prbs_cfg_ack_o : cdr_cfg_ack_o) != level && n < HS_MAX);
        if ((to_prbs ? prbs_cfg_ack_o : cdr_cfg_ack_o) != level) begin
            errors++;
            $display("handshake stuck at %0t: ack never went to %0d", $time, level);
        end
    endtask

    task automatic write_cfg(input bit to_prbs, input cdr_cfg_t cc, input prbs_cfg_t pc);
        @(posedge clk_adc);
        #1;
        if (to_prbs) begin
            prbs_cfg_i = pc;
            prbs_cfg_req_i = 1'b1;
        end else begin
            cdr_cfg_i = cc;
            cdr_cfg_req_i = 1'b1;
        end
        wait_ack(to_prbs, 1'b1);
        if (to_prbs) prbs_cfg_req_i = 1'b0;
        else cdr_cfg_req_i = 1'b0;
        wait_ack(to_prbs, 1'b0);
    endtask

    // model at the edge, check and drive 1 ns later
    initial begin
        forever begin
            @(posedge clk_adc);
            model_edge();
            #1;
            compare_outputs();
            drive_frame();
        end
    end

    initial begin
        cdr_cfg_t  cc;
        prbs_cfg_t pc;
        void'($urandom(29));
        errors = 0;
        checks = 0;
        g_hist = '1;
        tx_inv = 1'b0;
        cdr_rstb = 1'b0;
        adc_frame_i = '0;
        cdr_cfg_req_i = 1'b0;
        cdr_cfg_i = '0;
        prbs_cfg_req_i = 1'b0;
        prbs_cfg_i = '0;
        cc = '0;
        pc = '0;
        repeat (RST_CYCLES) @(posedge clk_adc);
        #1;
        cdr_rstb = 1'b1;
        // offsets written inside the startup wait
        cc.kp_shift = SHIFT_W'(2);
        cc.ki_shift = SHIFT_W'(6);
        cc.max_sel = 16'($urandom);
        cc.pi_offset = (NOUT * NPI)'({$urandom, $urandom});
        write_cfg(1'b0, cc, pc);
        repeat (WARMUP) @(posedge clk_adc);
        // gain sweep with scale and offset moving along
        for (int g = 0; g < 4; g++) begin
            cc.kp_shift = SHIFT_W'($urandom_range(6));
            cc.ki_shift = SHIFT_W'($urandom_range(12, 4));
            cc.max_sel = 16'($urandom);
            cc.pi_offset = (NOUT * NPI)'({$urandom, $urandom});
            write_cfg(1'b0, cc, pc);
            repeat (RUN_LEN) @(posedge clk_adc);
        end
        // map fields only while the gains stay
        for (int m = 0; m < 3; m++) begin
            cc.max_sel = 16'($urandom);
            cc.pi_offset = (NOUT * NPI)'({$urandom, $urandom});
            write_cfg(1'b0, cc, pc);
            repeat (RUN_LEN) @(posedge clk_adc);
        end
        ////////////////////////////////////////////////////////////////////
        // prbs checker runs
        ////////////////////////////////////////////////////////////////////
        pc.enable = 1'b1;
        pc.chan_sel = '1;
        for (int r = 0; r < 5; r++) begin
            if (r == 1) begin
                pc.chan_sel = 4'b0101;
                pc.thresh = (NADC + 1)'(int'($urandom_range(16)) - 8);
            end
            if (r == 2) begin
                tx_inv = 1'b1;
                pc.invert = 1'b1;
                pc.thresh = '0;
            end
            pc.enable = (r != 3);
            write_cfg(1'b1, cc, pc);
            repeat (RUN_LEN) @(posedge clk_adc);
        end
        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: cdr_core_props.sv
module cdr_core_props (
    input logic clk_adc,
    input logic cdr_rstb,
    input logic cdr_req_i,
    input logic cdr_ack_i,
    input logic prbs_req_i,
    input logic prbs_ack_i,
    input logic ctl_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // ack edges follow req as it was at the edge that moved ack
    cdr_ack_rise: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $rose(cdr_ack_i) |-> $past(cdr_req_i))
        else $error("cdr config ack rose with no request pending");

    cdr_ack_fall: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $fell(cdr_ack_i) |-> !$past(cdr_req_i))
        else $error("cdr config ack fell while request still high");

    prbs_ack_rise: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $rose(prbs_ack_i) |-> $past(prbs_req_i))
        else $error("prbs config ack rose with no request pending");

    prbs_ack_fall: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $fell(prbs_ack_i) |-> !$past(prbs_req_i))
        else $error("prbs config ack fell while request still high");

    // startup wait ends once
    valid_stays: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_i |=> ctl_valid_i)
        else $error("ctl_valid_o dropped after the startup wait");

endmodule

bind cdr_core cdr_core_props props_i (
    .clk_adc     (clk_adc),
    .cdr_rstb    (cdr_rstb),
    .cdr_req_i   (cdr_cfg_req_i),
    .cdr_ack_i   (cdr_cfg_ack_o),
    .prbs_req_i  (prbs_cfg_req_i),
    .prbs_ack_i  (prbs_cfg_ack_o),
    .ctl_valid_i (ctl_valid_o)
);

// File: cdr_core.sv
module cdr_core (
    input  logic                       clk_adc,
    input  logic                       cdr_rstb,
    input  cdr_pkg::adc_frame_t        adc_frame_i,

    input  logic                       cdr_cfg_req_i,
    input  cdr_pkg::cdr_cfg_t          cdr_cfg_i,
    output logic                       cdr_cfg_ack_o,

    input  logic                       prbs_cfg_req_i,
    input  cdr_pkg::prbs_cfg_t         prbs_cfg_i,
    output logic                       prbs_cfg_ack_o,

    output logic                       ctl_valid_o,
    output cdr_pkg::pi_vec_t           pi_ctl_o,
    output logic [cdr_pkg::CNT_W-1:0]  err_count_o,
    output logic [cdr_pkg::CNT_W-1:0]  total_count_o
);

    import cdr_pkg::*;

    cdr_cfg_t               cdr_cfg;
    prbs_cfg_t              prbs_cfg;
    code_vec_t              codes;
    logic signed [PD_W-1:0] pd_err;
    logic [NPI-1:0]         phase_code;

    //////////////////////////////////////////////////////////////////////
    // configuration registers
    //////////////////////////////////////////////////////////////////////

    cfg_regs #(
        .payload_t   (cdr_cfg_t),
        .reset_val_i (CDR_CFG_RST)
    ) cdr_cfg_regs (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .req_i    (cdr_cfg_req_i),
        .data_i   (cdr_cfg_i),
        .ack_o    (cdr_cfg_ack_o),
        .cfg_o    (cdr_cfg)
    );

    cfg_regs #(
        .payload_t   (prbs_cfg_t),
        .reset_val_i (PRBS_CFG_RST)
    ) prbs_cfg_regs (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .req_i    (prbs_cfg_req_i),
        .data_i   (prbs_cfg_i),
        .ack_o    (prbs_cfg_ack_o),
        .cfg_o    (prbs_cfg)
    );

    //////////////////////////////////////////////////////////////////////
    // receive pipeline
    //////////////////////////////////////////////////////////////////////

    adc_unfold adc_unfold_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_frame_i (adc_frame_i),
        .codes_o     (codes)
    );

    mm_phase_detector mm_pd_i (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .codes_i  (codes),
        .pd_err_o (pd_err)
    );

    cdr_loop_filter loop_filter_i (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .pd_err_i     (pd_err),
        .kp_shift_i   (cdr_cfg.kp_shift),
        .ki_shift_i   (cdr_cfg.ki_shift),
        .ctl_valid_o  (ctl_valid_o),
        .phase_code_o (phase_code)
    );

    // per-output scaling toward the analog PI
    pi_ctl_map pi_map_i (
        .phase_code_i (phase_code),
        .max_sel_i    (cdr_cfg.max_sel),
        .pi_offset_i  (cdr_cfg.pi_offset),
        .pi_ctl_o     (pi_ctl_o)
    );

    prbs_checker prbs_checker_i (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .codes_i       (codes),
        .cfg_i         (prbs_cfg),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

// File: prbs_checker.sv
module prbs_checker (
    input  logic                       clk_adc,
    input  logic                       cdr_rstb,
    input  cdr_pkg::code_vec_t         codes_i,
    input  cdr_pkg::prbs_cfg_t         cfg_i,
    output logic [cdr_pkg::CNT_W-1:0]  err_count_o,
    output logic [cdr_pkg::CNT_W-1:0]  total_count_o
);

    import cdr_pkg::*;

    localparam int NB_W = $clog2(NTI + 1);

    //////////////////////////////////////////////////////////////////////
    // slicer
    //////////////////////////////////////////////////////////////////////

    logic [NTI-1:0] bits_q;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            bits_q <= '0;
        end else begin
            for (int k = 0; k < NTI; k++) begin
                bits_q[k] <= (codes_i[k] > cfg_i.thresh) ^ cfg_i.invert;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // self-synchronizing check and counters
    //////////////////////////////////////////////////////////////////////

    // stream[PRBS_N-1:0] is history, newest at the top; frame bits above it
    logic [PRBS_N-1:0]     hist;
    logic [PRBS_N+NTI-1:0] stream;
    logic [NTI-1:0]        mismatch;
    logic [NB_W-1:0]       n_err;
    logic [NB_W-1:0]       n_tot;
    logic [CNT_W:0]        err_sum;
    logic [CNT_W:0]        tot_sum;

    assign stream = {bits_q, hist};

    always_comb begin
        n_err = '0;
        n_tot = '0;
        for (int k = 0; k < NTI; k++) begin
            // bit t against bits t-7 and t-6
            mismatch[k] = stream[PRBS_N+k] ^ stream[k] ^ stream[PRBS_N-PRBS_TAP2+k];
            n_err = n_err + NB_W'(mismatch[k] & cfg_i.chan_sel[k]);
            n_tot = n_tot + NB_W'(cfg_i.chan_sel[k]);
        end
    end

    assign err_sum = {1'b0, err_count_o} + (CNT_W+1)'(n_err);
    assign tot_sum = {1'b0, total_count_o} + (CNT_W+1)'(n_tot);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist          <= '0;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else begin
            hist <= stream[NTI +: PRBS_N];
            if (cfg_i.enable) begin
                // saturate instead of wrapping
                err_count_o   <= err_sum[CNT_W] ? '1 : err_sum[CNT_W-1:0];
                total_count_o <= tot_sum[CNT_W] ? '1 : tot_sum[CNT_W-1:0];
            end
        end
    end

endmodule

// File: pi_ctl_map.sv
module pi_ctl_map (
    input  logic [cdr_pkg::NPI-1:0]                   phase_code_i,
    input  logic [cdr_pkg::NOUT-1:0][3:0]             max_sel_i,
    input  logic [cdr_pkg::NOUT-1:0][cdr_pkg::NPI-1:0] pi_offset_i,
    output cdr_pkg::pi_vec_t                          pi_ctl_o
);

    import cdr_pkg::*;

    logic [NPI-1:0] scale [NOUT];
    logic [NPI-1:0] wrapped [NOUT];

    // scale = (max_sel + 1) * 16 - 1, so 15 up to 255
    always_comb begin
        for (int j = 0; j < NOUT; j++) begin
            scale[j] = ((NPI'(max_sel_i[j]) + NPI'(1)) << 4) - NPI'(1);
        end
    end

    // modulo first, then offset, sum wraps at NPI bits
    always_comb begin
        for (int j = 0; j < NOUT; j++) begin
            wrapped[j]  = phase_code_i % scale[j];
            pi_ctl_o[j] = wrapped[j] + pi_offset_i[j];
        end
    end

endmodule

// File: cdr_loop_filter.sv
module cdr_loop_filter (
    input  logic                              clk_adc,
    input  logic                              cdr_rstb,
    input  logic signed [cdr_pkg::PD_W-1:0]   pd_err_i,
    input  logic [cdr_pkg::SHIFT_W-1:0]       kp_shift_i,
    input  logic [cdr_pkg::SHIFT_W-1:0]       ki_shift_i,
    output logic                              ctl_valid_o,
    output logic [cdr_pkg::NPI-1:0]           phase_code_o
);

    import cdr_pkg::*;

    localparam int WAIT_W = $clog2(CTL_WAIT);

    //////////////////////////////////////////////////////////////////////
    // startup wait
    //////////////////////////////////////////////////////////////////////

    logic [WAIT_W-1:0] wait_cnt;
    logic              wait_done;

    assign wait_done = (wait_cnt == WAIT_W'(CTL_WAIT - 1));

    // valid one edge after the counter saturates
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt    <= '0;
            ctl_valid_o <= 1'b0;
        end else begin
            if (!wait_done) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            ctl_valid_o <= wait_done;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // proportional-integral path and phase accumulator
    //////////////////////////////////////////////////////////////////////

    logic signed [INTEG_W-1:0] pd_integ;
    logic signed [PHASE_W-1:0] pd_phase;
    logic signed [INTEG_W-1:0] integ;
    logic signed [PHASE_W-1:0] phase;

    assign pd_integ = {{(INTEG_W-PD_W){pd_err_i[PD_W-1]}}, pd_err_i};
    assign pd_phase = {{(PHASE_W-PD_W){pd_err_i[PD_W-1]}}, pd_err_i};

    // both registers wrap, the phase uses the integral before this edge
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            integ <= '0;
            phase <= '0;
        end else if (!ctl_valid_o) begin
            integ <= '0;
            phase <= '0;
        end else begin
            integ <= integ + (pd_integ >>> ki_shift_i);
            phase <= phase + (pd_phase >>> kp_shift_i) + PHASE_W'(integ);
        end
    end

    assign phase_code_o = phase[PHASE_W-1 -: NPI];

endmodule

// File: mm_phase_detector.sv
module mm_phase_detector (
    input  logic                        clk_adc,
    input  logic                        cdr_rstb,
    input  cdr_pkg::code_vec_t          codes_i,
    output logic signed [cdr_pkg::PD_W-1:0] pd_err_o
);

    import cdr_pkg::*;

    // last slice of the previous frame, x[-1] for slice 0
    code_t prev_last;

    // xw[0] is x[-1], xw[k+1] is x[k]
    logic signed [PD_W-1:0] xw [NTI+1];
    logic signed [PD_W-1:0] err_sum;

    always_comb begin
        xw[0] = {{(PD_W-NADC-1){prev_last[NADC]}}, prev_last};
        for (int k = 0; k < NTI; k++) begin
            xw[k+1] = {{(PD_W-NADC-1){codes_i[k][NADC]}}, codes_i[k]};
        end
    end

    // mueller-muller: s[k-1]*x[k] - s[k]*x[k-1], zero counts as positive
    always_comb begin
        logic signed [PD_W-1:0] early;
        logic signed [PD_W-1:0] late;
        err_sum = '0;
        for (int k = 1; k <= NTI; k++) begin
            early = (xw[k-1] >= 0) ? xw[k] : -xw[k];
            late  = (xw[k] >= 0) ? xw[k-1] : -xw[k-1];
            err_sum = err_sum + early - late;
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            prev_last <= '0;
            pd_err_o  <= '0;
        end else begin
            prev_last <= codes_i[NTI-1];
            pd_err_o  <= err_sum;
        end
    end

endmodule

// File: adc_unfold.sv
module adc_unfold (
    input  logic                  clk_adc,
    input  logic                  cdr_rstb,
    input  cdr_pkg::adc_frame_t   adc_frame_i,
    output cdr_pkg::code_vec_t    codes_o
);

    import cdr_pkg::*;

    code_vec_t codes_d;

    // sign-magnitude to two's complement, one extra bit for the sign
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            if (adc_frame_i.sign[k]) begin
                codes_d[k] = -$signed({1'b0, adc_frame_i.mag[k]});
            end else begin
                codes_d[k] = $signed({1'b0, adc_frame_i.mag[k]});
            end
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            codes_o <= '0;
        end else begin
            codes_o <= codes_d;
        end
    end

endmodule

// File: cfg_regs.sv
module cfg_regs #(
    parameter type      payload_t   = logic,
    parameter payload_t reset_val_i = '0
) (
    input  logic     clk_adc,
    input  logic     cdr_rstb,
    input  logic     req_i,
    input  payload_t data_i,
    output logic     ack_o,
    output payload_t cfg_o
);

    // four-phase slave
    // phase 1/2: req high with ack low -> capture and raise ack
    // phase 3/4: req low with ack high -> drop ack
    logic capture;
    logic release_ack;

    assign capture     = req_i & ~ack_o;
    assign release_ack = ~req_i & ack_o;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            ack_o <= 1'b0;
        end else if (capture) begin
            ack_o <= 1'b1;
        end else if (release_ack) begin
            ack_o <= 1'b0;
        end
    end

    // value moves in the same cycle ack rises
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            cfg_o <= reset_val_i;
        end else if (capture) begin
            cfg_o <= data_i;
        end
    end

endmodule

// File: cdr_pkg.sv
package cdr_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////////////////////////

    // interleaved slices and magnitude bits per slice
    localparam int NTI     = 4;
    localparam int NADC    = 8;

    // phase interpolator code and output count
    localparam int NPI     = 9;
    localparam int NOUT    = 4;

    // loop filter
    localparam int PHASE_W = 16;
    localparam int INTEG_W = 16;
    localparam int PD_W    = 14;
    localparam int SHIFT_W = 4;

    // prbs7 checker, taps at 7 and 6
    localparam int CNT_W     = 32;
    localparam int PRBS_N    = 7;
    localparam int PRBS_TAP2 = 6;

    // cycles the loop is held after reset
    localparam int CTL_WAIT = 32;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // sign bit set means negative slice
    typedef struct packed {
        logic [NTI-1:0][NADC-1:0] mag;
        logic [NTI-1:0]           sign;
    } adc_frame_t;

    typedef logic signed [NADC:0] code_t;
    typedef code_t [NTI-1:0] code_vec_t;

    typedef logic [NOUT-1:0][NPI-1:0] pi_vec_t;

    typedef struct packed {
        logic [SHIFT_W-1:0]        kp_shift;
        logic [SHIFT_W-1:0]        ki_shift;
        logic [NOUT-1:0][3:0]      max_sel;
        logic [NOUT-1:0][NPI-1:0]  pi_offset;
    } cdr_cfg_t;

    typedef struct packed {
        logic               enable;
        logic               invert;
        logic [NTI-1:0]     chan_sel;
        logic signed [NADC:0] thresh;
    } prbs_cfg_t;

    // register contents after reset
    localparam cdr_cfg_t CDR_CFG_RST = '{
        kp_shift:  SHIFT_W'(2),
        ki_shift:  SHIFT_W'(6),
        max_sel:   {NOUT{4'hf}},
        pi_offset: '0
    };

    localparam prbs_cfg_t PRBS_CFG_RST = '0;

endpackage
